//--- src/trig_cfg_pkg.sv
package trig_cfg_pkg;

    // beam count seen by the trigger path
    localparam int NBEAMS = 48;
    // mask is loaded in two halves, low half first
    localparam int MASK_LO_BITS = 30;
    localparam int MASK_HI_BITS = NBEAMS - MASK_LO_BITS;

    // at most one beam trigger per this many clocks
    localparam int HOLDOFF_CYCLES = 8;
    localparam int HOLDOFF_CNT_BITS = $clog2(HOLDOFF_CYCLES);

    // run address and metadata widths
    localparam int ADDR_BITS = 12;
    localparam int META_BITS = 8;

    // software periodic trigger period
    localparam int PERIOD_BITS = 16;

    // trigger fifo geometry
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_PTR_BITS = 4;
    localparam int FIFO_CNT_BITS = FIFO_PTR_BITS + 1;

    // output word, marker sits in the top two bits
    localparam int WORD_BITS = 32;
    localparam logic [1:0] WORD_MARKER = 2'b10;

endpackage

//--- src/trig_types_pkg.sv
package trig_types_pkg;

    // who produced a trigger word
    // encoding lands in bits 17:16 of the output word
    typedef enum logic [1:0] {
        // masked OR of the beam triggers
        SRC_BEAM     = 2'd0,
        // software force request
        SRC_FORCE    = 2'd1,
        // software periodic counter
        SRC_PERIODIC = 2'd2
    } trig_src_e;

    // beam generator retrigger guard
    typedef enum logic {
        // next surviving beam fires a strobe
        ST_ARMED   = 1'b0,
        // counting down, detections thrown away
        ST_HOLDOFF = 1'b1
    } holdoff_state_e;

endpackage

//--- src/beam_trig_gen.sv
`timescale 1ns/100ps

module beam_trig_gen (
    input  logic                                ifclk,
    input  logic                                runrst_i,
    input  logic [trig_cfg_pkg::NBEAMS-1:0]     trig_i,
    input  logic [trig_cfg_pkg::NBEAMS-1:0]     mask_i,
    input  logic [1:0]                          mask_wr_i,
    input  logic                                mask_update_i,
    output logic                                beam_stb_o,
    output logic [trig_cfg_pkg::META_BITS-1:0]  beam_meta_o
);
    import trig_cfg_pkg::*;
    import trig_types_pkg::*;

    // staging halves, written independently
    logic [MASK_LO_BITS-1:0]     stage_lo;
    logic [MASK_HI_BITS-1:0]     stage_hi;
    // mask in use, a 1 kills that beam
    logic [NBEAMS-1:0]           active_mask;
    // beams that survived the mask, one clock after trig_i
    logic [NBEAMS-1:0]           masked_q;
    logic                        any_hit;
    logic [META_BITS-1:0]        hit_count;
    holdoff_state_e              state;
    logic [HOLDOFF_CNT_BITS-1:0] holdoff_cnt;

    // mask double buffer
    always_ff @(posedge ifclk) begin
        if (runrst_i) begin
            stage_lo    <= '0;
            stage_hi    <= '0;
            active_mask <= '0;
        end else begin
            if (mask_wr_i[0]) begin
                stage_lo <= mask_i[MASK_LO_BITS-1:0];
            end
            if (mask_wr_i[1]) begin
                stage_hi <= mask_i[NBEAMS-1:MASK_LO_BITS];
            end
            // copies the staging value from before this edge
            if (mask_update_i) begin
                active_mask <= {stage_hi, stage_lo};
            end
        end
    end

    // register the surviving beams
    always_ff @(posedge ifclk) begin
        if (runrst_i) begin
            masked_q <= '0;
        end else begin
            masked_q <= trig_i & ~active_mask;
        end
    end

    // reductive or of the survivors
    assign any_hit = |masked_q;

    // metadata is the number of beams that fired
    always_comb begin
        hit_count = '0;
        for (int i = 0; i < NBEAMS; i++) begin
            hit_count = hit_count + META_BITS'(masked_q[i]);
        end
    end

    // holdoff fsm
    // strobe at edge e blocks edges e+1 .. e+HOLDOFF_CYCLES-1
    always_ff @(posedge ifclk) begin
        if (runrst_i) begin
            state       <= ST_ARMED;
            holdoff_cnt <= '0;
            beam_stb_o  <= 1'b0;
        end else begin
            beam_stb_o <= 1'b0;
            case (state)
                ST_ARMED: begin
                    if (any_hit) begin
                        beam_stb_o  <= 1'b1;
                        state       <= ST_HOLDOFF;
                        // last holdoff edge is the one that re-arms
                        holdoff_cnt <= HOLDOFF_CNT_BITS'(HOLDOFF_CYCLES - 2);
                    end
                end
                ST_HOLDOFF: begin
                    // hits seen here are simply dropped
                    if (holdoff_cnt == '0) begin
                        state <= ST_ARMED;
                    end else begin
                        holdoff_cnt <= holdoff_cnt - 1'b1;
                    end
                end
                default: begin
                    state <= ST_ARMED;
                end
            endcase
        end
    end

    // only meaningful alongside beam_stb_o
    always_ff @(posedge ifclk) begin
        beam_meta_o <= hit_count;
    end

endmodule

//--- src/soft_trig_gen.sv
`timescale 1ns/100ps

module soft_trig_gen (
    input  logic                                  ifclk,
    input  logic                                  runrst_i,
    input  logic                                  force_i,
    input  logic [trig_cfg_pkg::PERIOD_BITS-1:0]  period_i,
    output logic                                  soft_stb_o,
    output trig_types_pkg::trig_src_e             soft_src_o
);
    import trig_cfg_pkg::*;
    import trig_types_pkg::*;

    // last period seen, used to spot a new setting
    logic [PERIOD_BITS-1:0] period_q;
    logic [PERIOD_BITS-1:0] period_cnt;
    logic                   period_chg;
    logic                   period_hit;

    assign period_chg = (period_i != period_q);
    // zero period turns the periodic source off
    assign period_hit = (period_i != '0) && !period_chg &&
                        (period_cnt == period_i - 1'b1);

    always_ff @(posedge ifclk) begin
        period_q <= period_i;
    end

    // cycle counter, restarts on reset and on every period change
    always_ff @(posedge ifclk) begin
        if (runrst_i || period_chg || period_hit) begin
            period_cnt <= '0;
        end else if (period_i == '0) begin
            period_cnt <= '0;
        end else begin
            period_cnt <= period_cnt + 1'b1;
        end
    end

    // force and periodic in the same clock merge into one strobe
    always_ff @(posedge ifclk) begin
        if (runrst_i) begin
            soft_stb_o <= 1'b0;
        end else begin
            soft_stb_o <= force_i || period_hit;
        end
    end

    // force wins the source field
    always_ff @(posedge ifclk) begin
        soft_src_o <= force_i ? SRC_FORCE : SRC_PERIODIC;
    end

endmodule

//--- src/trig_arbiter.sv
`timescale 1ns/100ps

module trig_arbiter (
    input  logic                                ifclk,
    input  logic                                runrst_i,
    input  logic                                runstop_i,
    input  logic                                beam_stb_i,
    input  logic [trig_cfg_pkg::META_BITS-1:0]  beam_meta_i,
    input  logic                                soft_stb_i,
    input  trig_types_pkg::trig_src_e           soft_src_i,
    output logic                                fifo_wr_o,
    output logic [trig_cfg_pkg::WORD_BITS-1:0]  fifo_din_o
);
    import trig_cfg_pkg::*;
    import trig_types_pkg::*;

    logic                 running;
    // clock count since run start
    logic [ADDR_BITS-1:0] run_addr;
    // soft request that lost to a beam strobe
    logic                 soft_pend;
    trig_src_e            pend_src;
    logic                 grant_beam;
    logic                 grant_soft;
    trig_src_e            grant_src;
    logic [META_BITS-1:0] grant_meta;

    // run flag and address counter
    always_ff @(posedge ifclk) begin
        if (runrst_i) begin
            running  <= 1'b1;
            run_addr <= ADDR_BITS'(1);
        end else if (runstop_i || !running) begin
            running  <= 1'b0;
            run_addr <= ADDR_BITS'(1);
        end else begin
            run_addr <= run_addr + 1'b1;
        end
    end

    // beam always wins, pending soft goes ahead of a fresh one
    assign grant_beam = running && beam_stb_i;
    assign grant_soft = running && !beam_stb_i && (soft_pend || soft_stb_i);

    always_comb begin
        grant_src  = SRC_BEAM;
        grant_meta = beam_meta_i;
        if (!beam_stb_i) begin
            grant_src  = soft_pend ? pend_src : soft_src_i;
            // software words carry no beam count
            grant_meta = '0;
        end
    end

    // pending request bookkeeping
    always_ff @(posedge ifclk) begin
        if (runrst_i || !running) begin
            soft_pend <= 1'b0;
        end else if (beam_stb_i) begin
            soft_pend <= soft_pend || soft_stb_i;
        end else begin
            // pending one granted now, a new one waits a clock
            soft_pend <= soft_pend && soft_stb_i;
        end
    end

    always_ff @(posedge ifclk) begin
        if (soft_stb_i && (beam_stb_i || soft_pend)) begin
            pend_src <= soft_src_i;
        end
    end

    // fifo captures the word on the edge that ends the grant cycle
    // so the address is the one held before that edge's increment
    assign fifo_wr_o  = grant_beam || grant_soft;
    assign fifo_din_o = {WORD_MARKER, run_addr, grant_src, 8'h00, grant_meta};

endmodule

//--- src/trig_fifo.sv
`timescale 1ns/100ps

module trig_fifo (
    input  logic                                ifclk,
    input  logic                                runrst_i,
    input  logic                                wr_i,
    input  logic [trig_cfg_pkg::WORD_BITS-1:0]  din_i,
    output logic [trig_cfg_pkg::WORD_BITS-1:0]  trig_tdata_o,
    output logic                                trig_tvalid_o,
    input  logic                                trig_tready_i,
    output logic                                overflow_o
);
    import trig_cfg_pkg::*;

    logic [WORD_BITS-1:0]     mem [FIFO_DEPTH];
    logic [FIFO_PTR_BITS-1:0] wr_ptr;
    logic [FIFO_PTR_BITS-1:0] rd_ptr;
    // one bit wider than the pointers to tell full from empty
    logic [FIFO_CNT_BITS-1:0] count;
    logic                     full;
    logic                     do_wr;
    logic                     do_rd;

    assign full  = (count == FIFO_CNT_BITS'(FIFO_DEPTH));
    // writes into a full buffer are lost
    assign do_wr = wr_i && !full;
    assign do_rd = trig_tvalid_o && trig_tready_i;

    // storage
    always_ff @(posedge ifclk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din_i;
        end
    end

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge ifclk) begin
        if (runrst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // sticky until the next reset
    always_ff @(posedge ifclk) begin
        if (runrst_i) begin
            overflow_o <= 1'b0;
        end else if (wr_i && full) begin
            overflow_o <= 1'b1;
        end
    end

    // first word falls through, head of queue is always on the bus
    assign trig_tvalid_o = (count != '0);
    assign trig_tdata_o  = mem[rd_ptr];

endmodule

//--- src/surf_trig_top.sv
`timescale 1ns/100ps

module surf_trig_top (
    input  logic                                  ifclk,
    input  logic                                  runrst_i,
    input  logic                                  runstop_i,
    input  logic [trig_cfg_pkg::NBEAMS-1:0]       trig_i,
    input  logic [trig_cfg_pkg::NBEAMS-1:0]       mask_i,
    input  logic [1:0]                            mask_wr_i,
    input  logic                                  mask_update_i,
    input  logic                                  force_i,
    input  logic [trig_cfg_pkg::PERIOD_BITS-1:0]  period_i,
    output logic [trig_cfg_pkg::WORD_BITS-1:0]    trig_tdata_o,
    output logic                                  trig_tvalid_o,
    input  logic                                  trig_tready_i,
    output logic                                  overflow_o
);
    import trig_cfg_pkg::*;
    import trig_types_pkg::*;

    // beam path to arbiter
    logic                 beam_stb;
    logic [META_BITS-1:0] beam_meta;
    // software path to arbiter
    logic                 soft_stb;
    trig_src_e            soft_src;
    // arbiter to fifo
    logic                 fifo_wr;
    logic [WORD_BITS-1:0] fifo_din;

    beam_trig_gen u_beam (
        .ifclk         (ifclk),
        .runrst_i      (runrst_i),
        .trig_i        (trig_i),
        .mask_i        (mask_i),
        .mask_wr_i     (mask_wr_i),
        .mask_update_i (mask_update_i),
        .beam_stb_o    (beam_stb),
        .beam_meta_o   (beam_meta)
    );

    soft_trig_gen u_soft (
        .ifclk      (ifclk),
        .runrst_i   (runrst_i),
        .force_i    (force_i),
        .period_i   (period_i),
        .soft_stb_o (soft_stb),
        .soft_src_o (soft_src)
    );

    trig_arbiter u_arb (
        .ifclk       (ifclk),
        .runrst_i    (runrst_i),
        .runstop_i   (runstop_i),
        .beam_stb_i  (beam_stb),
        .beam_meta_i (beam_meta),
        .soft_stb_i  (soft_stb),
        .soft_src_i  (soft_src),
        .fifo_wr_o   (fifo_wr),
        .fifo_din_o  (fifo_din)
    );

    trig_fifo u_fifo (
        .ifclk         (ifclk),
        .runrst_i      (runrst_i),
        .wr_i          (fifo_wr),
        .din_i         (fifo_din),
        .trig_tdata_o  (trig_tdata_o),
        .trig_tvalid_o (trig_tvalid_o),
        .trig_tready_i (trig_tready_i),
        .overflow_o    (overflow_o)
    );

endmodule

//--- tests/tb_surf_trig.sv
`timescale 1ns/100ps

module tb_surf_trig;
    import trig_cfg_pkg::*;
    import trig_types_pkg::*;

    // cycle budget per test, drain included
    localparam int LEN_INIT = 20;
    localparam int LEN_MASK = 600;
    localparam int LEN_HOLD = 320;
    localparam int LEN_ARB = 200;
    localparam int LEN_PER = 380;
    localparam int LEN_RUN = 160;
    localparam int LEN_BP = 140;
    localparam int CYCLE_LIMIT = LEN_INIT + LEN_MASK + LEN_HOLD + LEN_ARB + LEN_PER
                                 + LEN_RUN + LEN_BP + 200;

    logic                   ifclk = 1'b0;
    logic                   runrst_i;
    logic                   runstop_i;
    logic [NBEAMS-1:0]      trig_i;
    logic [NBEAMS-1:0]      mask_i;
    logic [1:0]             mask_wr_i;
    logic                   mask_update_i;
    logic                   force_i;
    logic [PERIOD_BITS-1:0] period_i;
    logic [WORD_BITS-1:0]   trig_tdata_o;
    logic                   trig_tvalid_o;
    logic                   trig_tready_i;
    logic                   overflow_o;

    // reference model state
    logic [NBEAMS-1:0]      m_stage, m_active, m_masked;
    logic                   m_beam_stb, m_soft_stb, m_running, m_pend, m_ovf, m_rd_now;
    logic [META_BITS-1:0]   m_beam_meta;
    logic [PERIOD_BITS-1:0] m_pq = '0;
    logic [PERIOD_BITS-1:0] m_pcnt;
    logic [ADDR_BITS-1:0]   m_addr;
    trig_src_e              m_soft_src, m_pend_src;
    int                     m_block;
    logic [WORD_BITS-1:0]   exp_q[$];

    // bookkeeping
    logic [31:0]          lcg_state = 32'hbf6d_d382;
    int                   cycle_cnt = 0;
    int                   cur_test = 0;
    int                   err_test, err_total = 0, words_test;
    logic                 checking = 1'b0, hold_ready = 1'b0, stopped = 1'b0, want_first = 1'b0;
    logic                 have_beam, have_per;
    logic [ADDR_BITS-1:0] last_beam, last_per, prev_addr;
    trig_src_e            prev_src;

    surf_trig_top UUT (.*);

    initial begin
        ifclk = 1'b0;
        forever #4 ifclk = ~ifclk;
    end

    function automatic logic [31:0] rand32();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [NBEAMS-1:0] rand_beams();
        logic [63:0] w;
        w = {rand32(), rand32()};
        return w[NBEAMS-1:0];
    endfunction

    task automatic note_error();
        err_test++;
        err_total++;
    endtask

    task automatic check_addr(input logic [ADDR_BITS-1:0] got, input logic [ADDR_BITS-1:0] exp);
        if (got !== exp) begin
            $display("** Error: trig_tdata_o address got %h expected %h", got, exp);
            note_error();
        end
    endtask

    task automatic check_src(input trig_src_e got, input trig_src_e exp);
        if (got !== exp) begin
            $display("** Error: trig_tdata_o source got %h expected %h", got, exp);
            note_error();
        end
    endtask

    task automatic check_meta(input logic [META_BITS-1:0] got, input logic [META_BITS-1:0] exp);
        if (got !== exp) begin
            $display("** Error: trig_tdata_o meta got %h expected %h", got, exp);
            note_error();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            note_error();
        end
    endtask

    task automatic complain(input string what);
        $display("test %0d: %s", cur_test, what);
        note_error();
    endtask

    // one clock of the reference model, using values from before the edge
    task automatic model_step();
        logic [NBEAMS-1:0]    nxt_masked;
        logic                 nxt_beam, nxt_soft, chg, hit, wr;
        logic [META_BITS-1:0] nxt_meta, wmeta;
        trig_src_e            nxt_src, wsrc;
        int                   occ;
        nxt_masked = trig_i & ~m_active;
        nxt_meta = META_BITS'($countones(m_masked));
        nxt_beam = 1'b0;
        // strobe blocks the next HOLDOFF_CYCLES-1 edges
        if (m_block > 0) begin
            m_block--;
        end else if (m_masked != '0) begin
            nxt_beam = 1'b1;
            m_block = HOLDOFF_CYCLES - 1;
        end
        chg = (period_i != m_pq);
        hit = (period_i != '0) && !chg && (m_pcnt == period_i - 1'b1);
        nxt_soft = force_i || hit;
        nxt_src = force_i ? SRC_FORCE : SRC_PERIODIC;
        m_pcnt = (chg || hit || period_i == '0) ? '0 : m_pcnt + 1'b1;
        m_pq = period_i;
        // beam first, a losing soft request waits one clock
        wr = 1'b0;
        wsrc = SRC_BEAM;
        wmeta = '0;
        if (!m_running) begin
            m_pend = 1'b0;
        end else if (m_beam_stb) begin
            wr = 1'b1;
            wmeta = m_beam_meta;
            if (m_soft_stb) begin
                m_pend = 1'b1;
                m_pend_src = m_soft_src;
            end
        end else if (m_pend) begin
            wr = 1'b1;
            wsrc = m_pend_src;
            m_pend = m_soft_stb;
            m_pend_src = m_soft_src;
        end else if (m_soft_stb) begin
            wr = 1'b1;
            wsrc = m_soft_src;
        end
        // fifo occupancy as seen before the edge, a word leaving now still counts
        occ = exp_q.size() + (m_rd_now ? 1 : 0);
        m_rd_now = 1'b0;
        if (wr && occ >= FIFO_DEPTH) begin
            m_ovf = 1'b1;
        end else if (wr) begin
            exp_q.push_back({2'b10, m_addr, wsrc, 8'h00, wmeta});
        end
        if (runstop_i || !m_running) begin
            m_running = 1'b0;
            m_addr = ADDR_BITS'(1);
        end else begin
            m_addr = m_addr + 1'b1;
        end
        // update copies the old staging value
        if (mask_update_i) m_active = m_stage;
        if (mask_wr_i[0]) m_stage[MASK_LO_BITS-1:0] = mask_i[MASK_LO_BITS-1:0];
        if (mask_wr_i[1]) m_stage[NBEAMS-1:MASK_LO_BITS] = mask_i[NBEAMS-1:MASK_LO_BITS];
        m_masked = nxt_masked;
        m_beam_stb = nxt_beam;
        m_beam_meta = nxt_meta;
        m_soft_stb = nxt_soft;
        m_soft_src = nxt_src;
        if (runrst_i) begin
            {m_stage, m_active, m_masked} = '0;
            {m_beam_stb, m_soft_stb, m_pend, m_ovf} = '0;
            m_block = 0;
            m_pcnt = '0;
            m_running = 1'b1;
            m_addr = ADDR_BITS'(1);
            exp_q.delete();
        end
    endtask

    always @(posedge ifclk) begin
        model_step();
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run went past %0d cycles", CYCLE_LIMIT);
            $display("sim failed");
            $finish;
        end
    end

    // outputs are settled a little after the falling edge
    task automatic check_output();
        logic [WORD_BITS-1:0] w;
        logic [ADDR_BITS-1:0] a;
        trig_src_e            s;
        w = trig_tdata_o;
        a = w[29:18];
        s = trig_src_e'(w[17:16]);
        check_flag("overflow_o", overflow_o, m_ovf);
        check_flag("trig_tvalid_o", trig_tvalid_o, exp_q.size() != 0);
        if (!(trig_tvalid_o && trig_tready_i) || exp_q.size() == 0) return;
        check_addr(a, exp_q[0][29:18]);
        check_src(s, trig_src_e'(exp_q[0][17:16]));
        check_meta(w[7:0], exp_q[0][7:0]);
        if (w[31:30] !== 2'b10 || w[15:8] !== 8'h00) begin
            $display("** Error: trig_tdata_o framing got %h expected %h", w, exp_q[0]);
            note_error();
        end
        void'(exp_q.pop_front());
        m_rd_now = 1'b1;
        words_test++;
        if (cur_test == 2 && s == SRC_BEAM && have_beam && int'(a - last_beam) < HOLDOFF_CYCLES)
            complain("beam words closer together than the holdoff");
        if (cur_test == 3 && s == SRC_FORCE && (prev_src != SRC_BEAM || a != prev_addr + 1'b1))
            complain("force word did not follow its beam word one address later");
        if (cur_test == 4 && s == SRC_PERIODIC && have_per && int'(a - last_per) != int'(period_i))
            complain("periodic words not spaced by the period");
        if (stopped) complain("word came out after the run was stopped");
        if (want_first && a >= ADDR_BITS'(8)) complain("address did not restart near 1");
        want_first = 1'b0;
        if (s == SRC_BEAM) {have_beam, last_beam} = {1'b1, a};
        if (s == SRC_PERIODIC) {have_per, last_per} = {1'b1, a};
        prev_src = s;
        prev_addr = a;
    endtask

    always @(negedge ifclk) begin
        #1;
        if (checking) check_output();
    end

    // one clock, pulses fall back to idle
    task automatic step();
        @(negedge ifclk);
        trig_tready_i = hold_ready ? 1'b0 : (rand32() % 4 != 0);
        {trig_i, mask_wr_i, mask_update_i, force_i, runstop_i} = '0;
    endtask

    task automatic drain();
        repeat (12) step();
        while (exp_q.size() != 0 || trig_tvalid_o) step();
    endtask

    task automatic start_test(input int n);
        cur_test = n;
        {err_test, words_test} = '0;
        {have_beam, have_per} = '0;
    endtask

    task automatic end_test(input string name);
        $display("test %0d %s: %0d words, %0d errors", cur_test, name, words_test, err_test);
    endtask

    initial begin
        logic [31:0] r;
        int          per_len;
        {runstop_i, trig_i, mask_i, mask_wr_i, mask_update_i, force_i, period_i} = '0;
        trig_tready_i = 1'b1;
        runrst_i = 1'b1;
        repeat (10) step();
        runrst_i = 1'b0;
        checking = 1'b1;

        start_test(1);
        repeat (8) begin
            step();
            mask_i = rand_beams();
            mask_wr_i = 2'b01;
            step();
            mask_i = rand_beams();
            mask_wr_i = 2'b10;
            step();
            // about half the rounds keep the old mask active
            r = rand32();
            mask_update_i = r[0];
            repeat (60) begin
                step();
                r = rand32();
                if (r % 4 == 3) begin
                    // disabled beams only, no strobe may follow
                    trig_i = rand_beams() & m_active;
                end else if (r % 4 != 0) begin
                    trig_i = rand_beams() & rand_beams();
                end
            end
        end
        step();
        mask_i = '0;
        mask_wr_i = 2'b11;
        step();
        mask_update_i = 1'b1;
        drain();
        end_test("mask");

        start_test(2);
        repeat (6) begin
            repeat (30) begin
                step();
                trig_i = rand_beams();
            end
            repeat (12) step();
        end
        drain();
        end_test("holdoff");

        start_test(3);
        repeat (12) begin
            repeat (10) step();
            step();
            trig_i = rand_beams() | NBEAMS'(1);
            step();
            force_i = 1'b1;
        end
        drain();
        end_test("arbitration");

        start_test(4);
        step();
        period_i = PERIOD_BITS'(20 + rand32() % 40);
        per_len = int'(period_i);
        repeat (5 * per_len) step();
        period_i = '0;
        drain();
        if (words_test < 4) complain("too few periodic words");
        end_test("periodic");

        start_test(5);
        step();
        runstop_i = 1'b1;
        stopped = 1'b1;
        repeat (40) begin
            step();
            trig_i = rand_beams();
            force_i = (rand32() % 5 == 0);
        end
        repeat (12) step();
        stopped = 1'b0;
        runrst_i = 1'b1;
        repeat (10) step();
        runrst_i = 1'b0;
        want_first = 1'b1;
        step();
        trig_i = rand_beams() | NBEAMS'(1);
        drain();
        if (want_first) complain("no word after the run restarted");
        end_test("run control");

        start_test(6);
        hold_ready = 1'b1;
        repeat (20) begin
            step();
            force_i = 1'b1;
            step();
        end
        repeat (4) step();
        check_flag("overflow_o", overflow_o, 1'b1);
        hold_ready = 1'b0;
        drain();
        if (words_test != FIFO_DEPTH) complain("expected exactly 16 words out of a full FIFO");
        end_test("back-pressure");

        $display("tests run: 6, errors: %0d", err_total);
        if (err_total == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
src/trig_cfg_pkg.sv
src/trig_types_pkg.sv
src/beam_trig_gen.sv
src/soft_trig_gen.sv
src/trig_arbiter.sv
src/trig_fifo.sv
src/surf_trig_top.sv
tests/tb_surf_trig.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the trigger path testbench with verilator and runs it
# exit status is nonzero when the build breaks or the run reports failure

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --top-module tb_surf_trig -f verilog.f -o tb_surf_trig \
    > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_surf_trig > sim.log 2>&1 \
    || { echo "simulation exited with an error, see sim.log"; exit 1; }

grep -q "sim failed" sim.log \
    && { cat sim.log; echo "FAIL"; exit 1; } \
    || { cat sim.log; echo "PASS"; exit 0; }
